/* common/cpu_isa_pkg.sv */
/*
 * Instruction set definitions for the multicycle core.
 * Opcode map, instruction field positions, flag bit indices and small
 * opcode class helpers shared by the sequencer, execute unit and ALU.
 */

`default_nettype none

package cpu_isa_pkg;

    // Basic field types
    typedef logic [5:0] opcode_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [1:0] mode_t;

    // ----------------------------
    // Opcode map
    // ----------------------------

    // ALU group, 0x08..0x0A left unused
    localparam opcode_t OP_ADD   = 6'h00;
    localparam opcode_t OP_SUB   = 6'h01;
    localparam opcode_t OP_AND   = 6'h02;
    localparam opcode_t OP_OR    = 6'h03;
    localparam opcode_t OP_XOR   = 6'h04;
    localparam opcode_t OP_NOT   = 6'h05;
    localparam opcode_t OP_SHL   = 6'h06;
    localparam opcode_t OP_SHR   = 6'h07;
    localparam opcode_t OP_CMP   = 6'h0B;
    localparam opcode_t OP_SAR   = 6'h0C;

    // Memory group
    localparam opcode_t OP_LOAD  = 6'h10;
    localparam opcode_t OP_STORE = 6'h11;
    localparam opcode_t OP_LOADI = 6'h12;

    // Branch group, PC relative
    localparam opcode_t OP_JMP   = 6'h20;
    localparam opcode_t OP_JZ    = 6'h21;
    localparam opcode_t OP_JNZ   = 6'h22;
    localparam opcode_t OP_JC    = 6'h23;
    localparam opcode_t OP_JNC   = 6'h24;
    localparam opcode_t OP_JLT   = 6'h25;
    localparam opcode_t OP_JGE   = 6'h26;
    localparam opcode_t OP_JLE   = 6'h27;

    // Flag to register group
    localparam opcode_t OP_SETEQ = 6'h30;
    localparam opcode_t OP_SETNE = 6'h31;
    localparam opcode_t OP_SETLT = 6'h32;
    localparam opcode_t OP_SETGE = 6'h33;
    localparam opcode_t OP_SETLE = 6'h34;
    localparam opcode_t OP_SETGT = 6'h35;

    localparam opcode_t OP_HALT  = 6'h3E;

    // ----------------------------
    // Instruction fields
    // ----------------------------
    localparam int OPC_MSB  = 31;
    localparam int OPC_LSB  = 26;
    localparam int MODE_MSB = 25;
    localparam int MODE_LSB = 24;
    localparam int RD_MSB   = 23;
    localparam int RD_LSB   = 19;
    localparam int RS1_MSB  = 18;
    localparam int RS1_LSB  = 14;
    localparam int RS2_MSB  = 13;
    localparam int RS2_LSB  = 9;

    // Short immediate sits at the bottom, long one overlaps rs1..imm
    localparam int IMM_S_W  = 9;
    localparam int IMM_L_W  = 19;

    // Flag bit indices, bits 7..4 stay zero
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    // Opcode classes
    function automatic logic is_alu_op(input opcode_t op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_NOT, OP_SHL, OP_SHR, OP_CMP, OP_SAR: is_alu_op = 1'b1;
            default:                                is_alu_op = 1'b0;
        endcase
    endfunction

    function automatic logic is_branch_op(input opcode_t op);
        return (op >= OP_JMP) && (op <= OP_JLE);
    endfunction

    function automatic logic is_set_op(input opcode_t op);
        return (op >= OP_SETEQ) && (op <= OP_SETGT);
    endfunction

endpackage

`default_nettype wire

/* common/cpu_core_pkg.sv */
/*
 * Data path definitions for the multicycle core.
 * Word and flag types, the sequencer state encoding and the values
 * loaded on reset.
 */

`default_nettype none

package cpu_core_pkg;

    localparam int WORD_W  = 32;
    localparam int FLAGS_W = 8;

    // Data and address share one width
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [FLAGS_W-1:0] flags_t;

    // One pass per instruction, MEMORY only for LOAD and STORE
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } cpu_state_t;

    // Register file depth
    localparam int NUM_REGS = 32;

    // ----------------------------
    // Reset values
    // ----------------------------
    localparam word_t  RESET_PC    = 32'h0000_8000;
    localparam flags_t RESET_FLAGS = 8'h00;

endpackage

`default_nettype wire

/* common/cpu_if.sv */
/*
 * Internal interfaces of the core.
 * rf_if carries the register file ports between sequencer, execute unit
 * and register file. exec_if carries the decoded instruction from the
 * sequencer to the execute unit and returns the writeback data.
 */

`timescale 1ns/1ps
`default_nettype none

interface rf_if;
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    // Two combinational read ports
    reg_addr_t addr_a;
    reg_addr_t addr_b;
    word_t     data_a;
    word_t     data_b;

    // Single write port, written on the clock edge
    reg_addr_t addr_w;
    word_t     data_w;
    logic      we;

    // Sequencer does all addressing, also reads B for the store base
    modport seq  (output addr_a, addr_b, addr_w, we, input data_a, data_b);
    modport exec (output data_w, input data_a, data_b);
    modport rf   (input addr_a, addr_b, addr_w, data_w, we, output data_a, data_b);
endinterface

interface exec_if;
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    opcode_t opcode;
    word_t   imm;          // Already extended
    logic    exec_en;      // One cycle in EXECUTE
    logic    load_en;      // Read data valid for LOAD
    word_t   result;       // Writeback value
    logic    branch_taken;

    modport seq  (output opcode, imm, exec_en, load_en, input branch_taken);
    modport exec (input opcode, imm, exec_en, load_en, output result, branch_taken);
endinterface

`default_nettype wire

/* core/alu.sv */
/*
 * Combinational ALU with C, Z, N and V flag generation.
 * Shift amounts come from the low five bits of b. Opcodes outside the
 * ALU group give a zero result.
 */

`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_core_pkg::word_t    a,
    input  wire cpu_core_pkg::word_t    b,
    input  wire cpu_isa_pkg::opcode_t   op,
    output cpu_core_pkg::word_t         result,
    output cpu_core_pkg::flags_t        flags
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    // One extra bit keeps carry and borrow
    logic [WORD_W:0] sum;
    logic [WORD_W:0] diff;
    logic [4:0]      shamt;
    logic            add_v;
    logic            sub_v;

    assign sum   = {1'b0, a} + {1'b0, b};
    assign diff  = {1'b0, a} - {1'b0, b};
    assign shamt = b[4:0];

    // Overflow when operand signs allow it and the result sign flips
    assign add_v = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
    assign sub_v = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

    always_comb begin
        flags = '0;
        case (op)
            OP_ADD: begin
                result        = sum[WORD_W-1:0];
                flags[FLAG_C] = sum[WORD_W];
                flags[FLAG_V] = add_v;
            end
            // CMP writes back like SUB
            OP_SUB, OP_CMP: begin
                result        = diff[WORD_W-1:0];
                flags[FLAG_C] = diff[WORD_W];
                flags[FLAG_V] = sub_v;
            end
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_NOT:  result = ~a;
            OP_SHL:  result = a << shamt;
            OP_SHR:  result = a >> shamt;
            OP_SAR:  result = word_t'($signed(a) >>> shamt);
            default: result = '0;
        endcase
        flags[FLAG_Z] = (result == '0);
        flags[FLAG_N] = result[WORD_W-1];
    end

endmodule

`default_nettype wire

/* core/reg_file.sv */
/*
 * General purpose register file, 32 words.
 * Two combinational read ports and one write port taken on the rising
 * clock edge. All registers clear on reset.
 */

`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire clk,
    input  wire rst_n,
    rf_if.rf    rf
);
    import cpu_core_pkg::*;

    word_t regs_q [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rf.we) begin
            regs_q[rf.addr_w] <= rf.data_w;
        end
    end

    // Reads see the old value during a write cycle
    assign rf.data_a = regs_q[rf.addr_a];
    assign rf.data_b = regs_q[rf.addr_b];

endmodule

`default_nettype wire

/* core/exec_unit.sv */
/*
 * Execute unit of the core.
 * Wraps the ALU, keeps the flag, result and load data registers,
 * evaluates branch and SET conditions from the stored flags and picks
 * the value written back to the register file.
 */

`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire cpu_core_pkg::word_t    mem_rdata,
    output cpu_core_pkg::flags_t        cpu_flags,
    rf_if.exec                          rf,
    exec_if.exec                        ex
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    flags_t flags_q;
    word_t  result_q;
    word_t  load_q;

    word_t  alu_y;
    flags_t alu_flags;
    logic   set_bit;
    logic   flag_c;
    logic   flag_z;
    logic   flag_n;

    // Operands straight from the register file read ports
    alu i_alu (
        .a      (rf.data_a),
        .b      (rf.data_b),
        .op     (ex.opcode),
        .result (alu_y),
        .flags  (alu_flags)
    );

    assign flag_c = flags_q[FLAG_C];
    assign flag_z = flags_q[FLAG_Z];
    assign flag_n = flags_q[FLAG_N];

    // ----------------------------
    // Conditions
    // ----------------------------
    always_comb begin
        case (ex.opcode)
            OP_JMP:  ex.branch_taken = 1'b1;
            OP_JZ:   ex.branch_taken = flag_z;
            OP_JNZ:  ex.branch_taken = !flag_z;
            OP_JC:   ex.branch_taken = flag_c;
            OP_JNC:  ex.branch_taken = !flag_c;
            OP_JLT:  ex.branch_taken = flag_n;
            OP_JGE:  ex.branch_taken = !flag_n;
            OP_JLE:  ex.branch_taken = flag_z || flag_n;
            default: ex.branch_taken = 1'b0;
        endcase
    end

    // Signed compare taken from N alone, V is not folded in
    always_comb begin
        case (ex.opcode)
            OP_SETEQ: set_bit = flag_z;
            OP_SETNE: set_bit = !flag_z;
            OP_SETLT: set_bit = flag_n;
            OP_SETGE: set_bit = !flag_n;
            OP_SETLE: set_bit = flag_n || flag_z;
            OP_SETGT: set_bit = !flag_n && !flag_z;
            default:  set_bit = 1'b0;
        endcase
    end

    // ----------------------------
    // Registers
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= RESET_FLAGS;
        end else if (ex.exec_en && is_alu_op(ex.opcode)) begin
            flags_q <= alu_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.exec_en) begin
            result_q <= is_set_op(ex.opcode) ? {{(WORD_W-1){1'b0}}, set_bit} : alu_y;
        end
        if (ex.load_en) begin
            load_q <= mem_rdata;
        end
    end

    // Writeback select
    always_comb begin
        case (ex.opcode)
            OP_LOAD:  ex.result = load_q;
            OP_LOADI: ex.result = ex.imm;
            default:  ex.result = result_q;
        endcase
    end

    assign rf.data_w = ex.result;
    assign cpu_flags = flags_q;

endmodule

`default_nettype wire

/* core/cpu_sequencer.sv */
/*
 * Control sequencer of the core.
 * Steps each instruction through fetch, decode, execute, memory and
 * writeback, holds PC and instruction register, decodes fields and the
 * immediate, drives the memory request and the register file addressing.
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
    input  wire                         clk,
    input  wire                         rst_n,
    output cpu_core_pkg::word_t         mem_addr,
    output logic                        mem_read,
    output logic                        mem_write,
    output cpu_core_pkg::word_t         mem_wdata,
    input  wire cpu_core_pkg::word_t    mem_rdata,
    input  wire                         mem_ready,
    output logic                        halted,
    rf_if.seq                           rf,
    exec_if.seq                         ex
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    cpu_state_t state_q;
    cpu_state_t state_d;
    word_t      pc_q;
    word_t      ir_q;
    logic       boot_q;     // Low only in the first cycle out of reset

    // Decoded fields
    opcode_t          opcode;
    mode_t            mode;
    reg_addr_t        rd;
    reg_addr_t        rs1;
    reg_addr_t        rs2;
    logic [IMM_S_W-1:0] imm_s;
    logic [IMM_L_W-1:0] imm_l;
    word_t            imm;

    logic is_load;
    logic is_store;
    logic store_reg;        // Base register plus offset
    logic req_ok;

    // ----------------------------
    // Decode
    // ----------------------------
    assign opcode = ir_q[OPC_MSB:OPC_LSB];
    assign mode   = ir_q[MODE_MSB:MODE_LSB];
    assign rd     = ir_q[RD_MSB:RD_LSB];
    assign rs1    = ir_q[RS1_MSB:RS1_LSB];
    assign rs2    = ir_q[RS2_MSB:RS2_LSB];
    assign imm_s  = ir_q[IMM_S_W-1:0];
    assign imm_l  = ir_q[IMM_L_W-1:0];

    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign store_reg = is_store && (mode != '0);

    // Absolute addresses and LOADI zero extend the long field
    always_comb begin
        if (is_load || (opcode == OP_LOADI) || (is_store && !store_reg)) begin
            imm = {{(WORD_W - IMM_L_W){1'b0}}, imm_l};
        end else begin
            imm = {{(WORD_W - IMM_S_W){imm_s[IMM_S_W-1]}}, imm_s};
        end
    end

    // ----------------------------
    // State machine
    // ----------------------------
    assign req_ok = boot_q && !halted;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH:     if (req_ok && mem_ready) state_d = DECODE;
            DECODE:    state_d = EXECUTE;
            EXECUTE:   state_d = (is_load || is_store) ? MEMORY : WRITEBACK;
            MEMORY:    if (mem_ready) state_d = WRITEBACK;
            WRITEBACK: state_d = FETCH;
            default:   state_d = FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= FETCH;
            pc_q    <= RESET_PC;
            ir_q    <= '0;
            boot_q  <= 1'b0;
            halted  <= 1'b0;
        end else begin
            state_q <= state_d;
            boot_q  <= 1'b1;
            // Instruction arrives with mem_ready, PC moves past it
            if (state_q == FETCH && req_ok && mem_ready) begin
                ir_q <= mem_rdata;
                pc_q <= pc_q + 32'd4;
            end
            if (state_q == EXECUTE) begin
                // Offset is in words, relative to the next instruction
                if (ex.branch_taken) begin
                    pc_q <= pc_q + {imm[WORD_W-3:0], 2'b00};
                end
                if (opcode == OP_HALT) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    // ----------------------------
    // Memory port
    // ----------------------------
    assign mem_read  = !halted && (((state_q == FETCH) && boot_q) ||
                                   ((state_q == MEMORY) && is_load));
    assign mem_write = !halted && (state_q == MEMORY) && is_store;

    // Registers only change in WRITEBACK so address and data hold
    assign mem_addr  = (state_q != MEMORY) ? pc_q :
                       store_reg           ? rf.data_b + imm :
                                             imm;
    assign mem_wdata = rf.data_a;

    // Register file addressing, STORE data comes from rd
    assign rf.addr_a = is_store  ? rd  : rs1;
    assign rf.addr_b = store_reg ? rs1 : rs2;
    assign rf.addr_w = rd;
    assign rf.we     = (state_q == WRITEBACK) && !is_store &&
                       (opcode != OP_HALT) && !is_branch_op(opcode);

    // To execute unit
    assign ex.opcode  = opcode;
    assign ex.imm     = imm;
    assign ex.exec_en = (state_q == EXECUTE);
    assign ex.load_en = (state_q == MEMORY) && is_load && mem_ready;

endmodule

`default_nettype wire

/* hdl/cpu_top.sv */
/*
 * Top level of the multicycle 32-bit core.
 * Connects sequencer, execute unit and register file through the
 * internal interfaces and exposes the memory handshake and status as
 * plain ports. A request holds until mem_ready is seen.
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire                         clk,
    input  wire                         rst_n,

    // Memory port
    output wire cpu_core_pkg::word_t    mem_addr,
    output wire                         mem_read,
    output wire                         mem_write,
    output wire cpu_core_pkg::word_t    mem_wdata,
    input  wire cpu_core_pkg::word_t    mem_rdata,
    input  wire                         mem_ready,

    // Status
    output wire                         halted,
    output wire cpu_core_pkg::flags_t   cpu_flags
);

    // Internal buses
    rf_if   i_rf_if ();
    exec_if i_ex_if ();

    // ----------------------------
    // Control
    // ----------------------------
    cpu_sequencer i_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .halted    (halted),
        .rf        (i_rf_if.seq),
        .ex        (i_ex_if.seq)
    );

    // ----------------------------
    // Data path
    // ----------------------------
    exec_unit i_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .cpu_flags (cpu_flags),
        .rf        (i_rf_if.exec),
        .ex        (i_ex_if.exec)
    );

    reg_file i_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (i_rf_if.rf)
    );

endmodule

`default_nettype wire

/* tests/cpu_chk.sv */
/*
 * Bus protocol assertions, bound to the core top level.
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_chk (
    input wire                      clk,
    input wire                      rst_n,
    input wire cpu_core_pkg::word_t mem_addr,
    input wire                      mem_read,
    input wire                      mem_write,
    input wire cpu_core_pkg::word_t mem_wdata,
    input wire                      mem_ready,
    input wire                      halted
);

    a_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write)) else $error("read and write together");

    // Request held until mem_ready
    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read && !mem_ready) |=> mem_read && $stable(mem_addr))
        else $error("read request dropped or changed");

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_write && !mem_ready) |=> mem_write && $stable(mem_addr) && $stable(mem_wdata))
        else $error("write request dropped or changed");

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted) else $error("halted fell");

    a_halt_idle: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !mem_read && !mem_write) else $error("request while halted");

endmodule

bind cpu_top cpu_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .halted    (halted)
);

`default_nettype wire

/* tests/tb_cpu.sv */
/*
 * Testbench for the multicycle core.
 * Assembles a fixed program at 0x8000, runs a reference model over it
 * and checks every store of the DUT against the model, once with an
 * always ready memory and once with random wait states.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_isa_pkg::*;

    localparam int MEM_WORDS = 16384;

    logic        clk;
    logic        rst_n;
    logic [31:0] mem_addr;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_ready;
    logic        halted;
    logic [7:0]  cpu_flags;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [7:0]  exp_flags;
    logic [31:0] lfsr_q;
    logic [31:0] slot_addr;
    logic        stall_en;
    int          exp_idx;
    int          errors;

    cpu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .halted    (halted),
        .cpu_flags (cpu_flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            // Galois step, taps 32,30,26,25
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // Background contents, every address gives its own word
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] enc(input opcode_t op, input logic [1:0] mode,
                                        input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2, input logic [8:0] imm9);
        return {op, mode, rd, rs1, rs2, imm9};
    endfunction

    function automatic logic [31:0] enc_long(input opcode_t op, input reg_addr_t rd,
                                             input logic [18:0] imm19);
        return {op, 2'b00, rd, imm19};
    endfunction

    // Direct store of rd to the next result slot
    function automatic void store_slot(input reg_addr_t rd);
        prog.push_back(enc_long(OP_STORE, rd, slot_addr[18:0]));
        slot_addr = slot_addr + 32'd4;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------
    // Program
    // ------------------------------
    task automatic build_program();
        opcode_t alu_ops [10];
        opcode_t br_ops [8];
        opcode_t set_ops [6];
        reg_addr_t cmp_a [3];
        reg_addr_t cmp_b [3];
        logic [31:0] rnd [4];
        alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                    OP_NOT, OP_SHL, OP_SHR, OP_SAR, OP_CMP};
        br_ops  = '{OP_JMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC, OP_JLT, OP_JGE, OP_JLE};
        set_ops = '{OP_SETEQ, OP_SETNE, OP_SETLT, OP_SETGE, OP_SETLE, OP_SETGT};
        // Equal, less and greater pairs
        cmp_a = '{5'd11, 5'd13, 5'd11};
        cmp_b = '{5'd12, 5'd11, 5'd13};
        slot_addr = 32'h100;
        // Random 19-bit fields in program order
        foreach (rnd[i]) begin
            rnd[i] = take_bits(19);
        end
        // Build two wide random operands in r1 and r2
        prog.push_back(enc_long(OP_LOADI, 5'd3, 19'd13));
        prog.push_back(enc_long(OP_LOADI, 5'd1, rnd[0][18:0]));
        prog.push_back(enc(OP_SHL, 2'd0, 5'd1, 5'd1, 5'd3, 9'd0));
        prog.push_back(enc_long(OP_LOADI, 5'd4, rnd[1][18:0]));
        prog.push_back(enc(OP_XOR, 2'd0, 5'd1, 5'd1, 5'd4, 9'd0));
        prog.push_back(enc_long(OP_LOADI, 5'd2, rnd[2][18:0]));
        prog.push_back(enc(OP_SHL, 2'd0, 5'd2, 5'd2, 5'd3, 9'd0));
        prog.push_back(enc_long(OP_LOADI, 5'd4, rnd[3][18:0]));
        prog.push_back(enc(OP_OR, 2'd0, 5'd2, 5'd2, 5'd4, 9'd0));
        foreach (alu_ops[i]) begin
            prog.push_back(enc(alu_ops[i], 2'd0, 5'd5, 5'd1, 5'd2, 9'd0));
            store_slot(5'd5);
        end
        // Loads from a written slot and from untouched memory
        prog.push_back(enc_long(OP_LOAD, 5'd6, 19'h100));
        store_slot(5'd6);
        prog.push_back(enc_long(OP_LOAD, 5'd6, 19'h3f0));
        store_slot(5'd6);
        // Register offset store, base 0x300 minus 8
        prog.push_back(enc_long(OP_LOADI, 5'd7, 19'h300));
        prog.push_back(enc(OP_STORE, 2'd1, 5'd6, 5'd7, 5'd0, 9'h1f8));
        prog.push_back(enc_long(OP_LOADI, 5'd8, 19'h1234));
        prog.push_back(enc_long(OP_LOADI, 5'd9, 19'h5678));
        prog.push_back(enc_long(OP_LOADI, 5'd11, 19'd5));
        prog.push_back(enc_long(OP_LOADI, 5'd12, 19'd5));
        prog.push_back(enc_long(OP_LOADI, 5'd13, 19'd3));
        // Taken branch skips the first of two stores
        foreach (cmp_a[p]) begin
            foreach (br_ops[i]) begin
                prog.push_back(enc(OP_CMP, 2'd0, 5'd20, cmp_a[p], cmp_b[p], 9'd0));
                prog.push_back(enc(br_ops[i], 2'd0, 5'd0, 5'd0, 5'd0, 9'd1));
                store_slot(5'd8);
                store_slot(5'd9);
            end
            foreach (set_ops[i]) begin
                prog.push_back(enc(OP_CMP, 2'd0, 5'd20, cmp_a[p], cmp_b[p], 9'd0));
                prog.push_back(enc(set_ops[i], 2'd0, 5'd10, 5'd0, 5'd0, 9'd0));
                store_slot(5'd10);
            end
        end
        // Last compare, 3 minus 5, leaves C and N set at halt
        prog.push_back(enc(OP_CMP, 2'd0, 5'd20, 5'd13, 5'd11, 9'd0));
        prog.push_back(enc(OP_HALT, 2'd0, 5'd0, 5'd0, 5'd0, 9'd0));
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic void run_model();
        logic [31:0] regs [32];
        logic [31:0] mm [logic [31:0]];
        logic [31:0] pc, ir, a, b, y, addr, sx9;
        logic [32:0] wide;
        logic [7:0]  f;
        logic        c, v, alu, take, done;
        opcode_t     op;
        reg_addr_t   rd, rs1, rs2;
        foreach (regs[i]) regs[i] = '0;
        foreach (prog[k]) mm[32'h8000 + 32'(k) * 4] = prog[k];
        pc = 32'h8000;
        f = '0;
        done = 1'b0;
        for (int step = 0; step < 5000 && !done; step++) begin
            ir = mm.exists(pc) ? mm[pc] : fill_word(pc);
            pc = pc + 4;
            op = ir[31:26];
            rd = ir[23:19];
            rs1 = ir[18:14];
            rs2 = ir[13:9];
            sx9 = {{23{ir[8]}}, ir[8:0]};
            a = regs[rs1];
            b = regs[rs2];
            c = 1'b0;
            v = 1'b0;
            alu = 1'b1;
            y = '0;
            case (op)
                OP_ADD: begin
                    wide = {1'b0, a} + {1'b0, b};
                    y = wide[31:0];
                    c = wide[32];
                    v = (a[31] == b[31]) && (y[31] != a[31]);
                end
                OP_SUB, OP_CMP: begin
                    y = a - b;
                    c = a < b;
                    v = (a[31] != b[31]) && (y[31] != a[31]);
                end
                OP_AND: y = a & b;
                OP_OR:  y = a | b;
                OP_XOR: y = a ^ b;
                OP_NOT: y = ~a;
                OP_SHL: y = a << b[4:0];
                OP_SHR: y = a >> b[4:0];
                OP_SAR: y = 32'($signed(a) >>> b[4:0]);
                default: alu = 1'b0;
            endcase
            if (alu) begin
                f = {4'b0, v, y[31], y == 32'd0, c};
                regs[rd] = y;
            end else if (op == OP_LOADI) begin
                regs[rd] = {13'd0, ir[18:0]};
            end else if (op == OP_LOAD) begin
                addr = {13'd0, ir[18:0]};
                regs[rd] = mm.exists(addr) ? mm[addr] : fill_word(addr);
            end else if (op == OP_STORE) begin
                addr = (ir[25:24] == 2'd0) ? {13'd0, ir[18:0]} : a + sx9;
                mm[addr] = regs[rd];
                exp_addr.push_back(addr);
                exp_data.push_back(regs[rd]);
            end else if (op >= OP_JMP && op <= OP_JLE) begin
                // Flag bits C=0 Z=1 N=2
                case (op)
                    OP_JZ:   take = f[1];
                    OP_JNZ:  take = !f[1];
                    OP_JC:   take = f[0];
                    OP_JNC:  take = !f[0];
                    OP_JLT:  take = f[2];
                    OP_JGE:  take = !f[2];
                    OP_JLE:  take = f[1] || f[2];
                    default: take = 1'b1;
                endcase
                if (take) pc = pc + (sx9 << 2);
            end else if (op >= OP_SETEQ && op <= OP_SETGT) begin
                case (op)
                    OP_SETEQ: take = f[1];
                    OP_SETNE: take = !f[1];
                    OP_SETLT: take = f[2];
                    OP_SETGE: take = !f[2];
                    OP_SETLE: take = f[1] || f[2];
                    default:  take = !f[1] && !f[2];
                endcase
                regs[rd] = {31'd0, take};
            end else if (op == OP_HALT) begin
                done = 1'b1;
            end
        end
        exp_flags = f;
    endfunction

    // ------------------------------
    // Memory model and compare
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
        end else if ((mem_read || mem_write) && mem_ready) begin
            if (mem_write) mem[mem_addr[15:2]] = mem_wdata;
            mem_ready <= 1'b0;
        end else if (mem_read || mem_write) begin
            mem_rdata <= mem[mem_addr[15:2]];
            mem_ready <= stall_en ? take_bits(1) != 32'd0 : 1'b1;
        end else begin
            mem_ready <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst_n && mem_write && mem_ready) begin
            if (exp_idx >= exp_addr.size()) begin
                $display("Store to 0x%08h beyond the expected store list", mem_addr);
                errors++;
            end else begin
                check_val("mem_addr", mem_addr, exp_addr[exp_idx]);
                check_val("mem_wdata", mem_wdata, exp_data[exp_idx]);
            end
            exp_idx++;
        end
    end

    task automatic run_program(input logic stalls);
        int cnt;
        stall_en = stalls;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(32'(i) * 4);
        foreach (prog[k]) mem[(32'h8000 >> 2) + k] = prog[k];
        exp_idx = 0;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        cnt = 0;
        while (!halted && cnt < 20000) begin
            @(negedge clk);
            cnt++;
        end
        if (!halted) begin
            $display("Timeout waiting for halted, stalls %0d", stalls);
            errors++;
        end
        // Idle window, no fetch allowed
        for (cnt = 0; cnt < 50; cnt++) begin
            @(negedge clk);
            if (mem_read) begin
                $display("Memory read issued after halt");
                errors++;
            end
        end
        check_val("store_count", 32'(exp_idx), 32'(exp_addr.size()));
        check_val("cpu_flags", {24'd0, cpu_flags}, {24'd0, exp_flags});
        check_val("halted", {31'd0, halted}, 32'd1);
    endtask

    initial begin
        rst_n = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        stall_en = 1'b0;
        exp_idx = 0;
        errors = 0;
        lfsr_q = 32'hfbd9_05be;
        build_program();
        run_model();
        run_program(1'b0);
        run_program(1'b1);
        $display("Errors: %0d, stores expected per run: %0d", errors, exp_addr.size());
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/cpu_isa_pkg.sv
common/cpu_core_pkg.sv
common/cpu_if.sv
core/alu.sv
core/reg_file.sv
core/exec_unit.sv
core/cpu_sequencer.sv
hdl/cpu_top.sv
tests/cpu_chk.sv
tests/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_cpu
FILELIST  := tb.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
